//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
RUN_FLAGS  = +verilator+error+limit+100
TOP        = soc_tester_tb
FILELIST   = soc_tester.f
LOG        = sim.log
FAIL_MSG   = Something failed
PASS_MSG   = Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- soc_tester.f
verilog/soc_bus_pkg.sv
verilog/tester_cmd_pkg.sv
verilog/soc_reset_sync.sv
verilog/tester_decode.sv
verilog/tester_exec.sv
verilog/tester_result.sv
verilog/wb_shared_arbiter.sv
verilog/wb_ram.sv
verilog/soc_tester_top.sv
tb/soc_tester_sva.sv
tb/soc_tester_tb.sv

//--- tb/soc_tester_sva.sv
`timescale 1ns/1ns

module soc_tester_sva (
   input logic                 clk,
   input logic                 reset,
   input logic                 rst,
   input logic                 init_done,
   input logic                 cmd_ack,
   input soc_bus_pkg::wb_rsp_t exec_rsp,
   input soc_bus_pkg::wb_req_t sut_req,
   input soc_bus_pkg::wb_rsp_t sut_rsp,
   input logic                 trap,
   input logic                 done
);

   int fail_count = 0;

   // Sampled mid-cycle, away from the driving edge
   ack_after_clear: assert property (@(negedge clk) disable iff (reset)
      cmd_ack |-> init_done)
      else begin
         fail_count++;
         $error("cmd_ack seen before the RAM clear finished");
      end

   cmd_ack_pulse: assert property (@(negedge clk) disable iff (rst) cmd_ack |=> !cmd_ack)
      else begin
         fail_count++;
         $error("cmd_ack high two cycles in a row");
      end

   sut_ack_in_cycle: assert property (@(negedge clk) disable iff (rst)
      sut_rsp.ack |-> (sut_req.cyc && sut_req.stb))
      else begin
         fail_count++;
         $error("SUT ack without an open request");
      end

   // One ack per SUT request
   sut_ack_single: assert property (@(negedge clk) disable iff (rst) sut_rsp.ack |=> !sut_rsp.ack)
      else begin
         fail_count++;
         $error("SUT request acked more than once");
      end

   one_owner: assert property (@(negedge clk) disable iff (rst) !(exec_rsp.ack && sut_rsp.ack))
      else begin
         fail_count++;
         $error("Both masters acked in one cycle");
      end

   status_sticky: assert property (@(negedge clk) disable iff (rst)
      (trap || done) |=> ((trap || !$past(trap)) && (done || !$past(done))))
      else begin
         fail_count++;
         $error("trap or done fell without a reset");
      end

endmodule

bind soc_tester_top soc_tester_sva sva_i (
   .clk(clk), .reset(reset), .rst(rst), .init_done(init_done), .cmd_ack(cmd_ack),
   .exec_rsp(exec_rsp), .sut_req(sut_req), .sut_rsp(sut_rsp),
   .trap(trap), .done(done)
);

//--- tb/soc_tester_tb.sv
`timescale 1ns/1ns

module soc_tester_tb;

   import soc_bus_pkg::*;
   import tester_cmd_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int CLEAR_CYCLES = RAM_DEPTH + 4;   // Sweep plus reset release
   localparam int NUM_CMDS     = 40;
   localparam int CMD_CYCLES   = 12;
   // Two clears since the last test starts over
   localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + CLEAR_CYCLES) + NUM_CMDS * CMD_CYCLES + 200;

   logic        clk;
   logic        reset;
   logic        cmd_cyc;
   logic        cmd_stb;
   tester_cmd_u cmd_dat;
   logic        cmd_ack;
   wb_req_t     sut_req;
   wb_rsp_t     sut_rsp;
   logic        sut_trap;
   logic        trap;
   logic        done;
   logic [7:0]  err_count;
   logic [7:0]  fail_addr;
   logic [7:0]  finish_code;

   // Reference state built from our own traffic
   logic [DATA_W-1:0] mem_model [RAM_DEPTH];
   logic [DATA_W-1:0] mask_model;
   logic [ADDR_W-1:0] exp_fail_addr;
   logic              exp_trap;
   logic              exp_done;
   logic [7:0]        exp_code;
   int                exp_err;

   integer seed = 32'h7e86105c;
   int     cycles = 0;
   int     records = 0;   // Check records seen leaving execute
   int     issued = 0;    // Commands that produce a record
   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     test_start_err = 0;

   soc_tester_top soc_tester_top_i (
      .clk(clk), .reset(reset),
      .cmd_cyc(cmd_cyc), .cmd_stb(cmd_stb), .cmd_dat(cmd_dat), .cmd_ack(cmd_ack),
      .sut_req(sut_req), .sut_rsp(sut_rsp), .sut_trap(sut_trap),
      .trap(trap), .done(done), .err_count(err_count),
      .fail_addr(fail_addr), .finish_code(finish_code)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (soc_tester_top_i.check.valid) records <= records + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped by timeout after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end
   end

   // ------------------------------
   // Helpers
   // ------------------------------

   function automatic int total_errors();
      return errors + soc_tester_top_i.sva_i.fail_count;
   endfunction

   function automatic tester_cmd_u make_access(input cmd_op_e op, input logic [ADDR_W-1:0] addr,
                                               input logic [DATA_W-1:0] data);
      tester_cmd_u word;
      word = '0;
      word.access.opcode = op;
      word.access.addr   = addr;
      word.access.data   = data;
      return word;
   endfunction

   function automatic tester_cmd_u make_ctrl(input cmd_op_e op, input logic [7:0] code,
                                             input logic [DATA_W-1:0] mask);
      tester_cmd_u word;
      word = '0;
      word.ctrl.opcode      = op;
      word.ctrl.finish_code = code;
      word.ctrl.mask        = mask;
      return word;
   endfunction

   task automatic send_cmd(input tester_cmd_u word);
      @(posedge clk);
      cmd_cyc <= 1'b1;
      cmd_stb <= 1'b1;
      cmd_dat <= word;
      @(posedge clk);
      while (!cmd_ack) @(posedge clk);
      cmd_cyc <= 1'b0;
      cmd_stb <= 1'b0;
      if (word.access.opcode != CMD_SET_MASK) issued++;   // Mask updates leave no record
   endtask

   task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      send_cmd(make_access(CMD_WRITE, addr, data));
      mem_model[addr] = data;
   endtask

   task automatic do_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
      send_cmd(make_access(CMD_CHECK, addr, expected));
      if ((mem_model[addr] & mask_model) != (expected & mask_model)) begin
         exp_err++;
         exp_fail_addr = addr;
         exp_trap      = 1'b1;
      end
   endtask

   task automatic do_mask(input logic [DATA_W-1:0] mask);
      send_cmd(make_ctrl(CMD_SET_MASK, 8'h00, mask));
      mask_model = mask;
   endtask

   task automatic sut_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk);
      sut_req.cyc <= 1'b1;
      sut_req.stb <= 1'b1;
      sut_req.we  <= 1'b1;
      sut_req.adr <= addr;
      sut_req.dat <= data;
      @(posedge clk);
      while (!sut_rsp.ack) @(posedge clk);
      sut_req.cyc <= 1'b0;
      sut_req.stb <= 1'b0;
      sut_req.we  <= 1'b0;
      mem_model[addr] = data;
   endtask

   task automatic sut_read(input logic [ADDR_W-1:0] addr);
      @(posedge clk);
      sut_req.cyc <= 1'b1;
      sut_req.stb <= 1'b1;
      sut_req.we  <= 1'b0;
      sut_req.adr <= addr;
      @(posedge clk);
      while (!sut_rsp.ack) @(posedge clk);
      expect_value("sut_rsp.dat", 32'(sut_rsp.dat), 32'(mem_model[addr]));
      sut_req.cyc <= 1'b0;
      sut_req.stb <= 1'b0;
   endtask

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_status();
      while (records != issued) @(posedge clk);
      expect_value("err_count", 32'(err_count), exp_err);
      expect_value("trap", 32'(trap), 32'(exp_trap));
      expect_value("done", 32'(done), 32'(exp_done));
      if (exp_err != 0) expect_value("fail_addr", 32'(fail_addr), 32'(exp_fail_addr));
      if (exp_done) expect_value("finish_code", 32'(finish_code), 32'(exp_code));
   endtask

   task automatic apply_reset();
      int i;
      reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      for (i = 0; i < RAM_DEPTH; i++) mem_model[i] = '0;   // RAM clears itself
      mask_model = MASK_ALL;
      exp_err    = 0;
      exp_trap   = 1'b0;
      exp_done   = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (total_errors() == test_start_err) $display("test %0s passed", name);
      else $display("test %0s failed", name);
      test_start_err = total_errors();
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      logic [31:0]       rnd;
      logic [ADDR_W-1:0] addrs [8];
      logic [DATA_W-1:0] host_data [6];
      logic [DATA_W-1:0] sut_data [6];
      int                i;
      reset    = 1'b1;
      cmd_cyc  = 1'b0;
      cmd_stb  = 1'b0;
      cmd_dat  = '0;
      sut_req  = '0;
      sut_trap = 1'b0;
      apply_reset();

      // Commands wait out the clear
      for (i = 0; i < 3; i++) begin
         rnd = $random(seed);
         do_check(rnd[7:0], '0);
      end
      check_status();
      end_test("reset_clear");

      for (i = 0; i < 8; i++) begin
         rnd      = $random(seed);
         addrs[i] = rnd[7:0];
         do_write(rnd[7:0], rnd[31:16]);
      end
      for (i = 0; i < 8; i++) do_check(addrs[i], mem_model[addrs[i]]);
      check_status();
      end_test("write_check");

      do_check(addrs[0], mem_model[addrs[0]] ^ 16'h0100);
      check_status();
      end_test("mismatch");

      do_mask(16'hff00);
      do_check(addrs[1], mem_model[addrs[1]] ^ 16'h00a5);   // Only masked-out bits differ
      do_check(addrs[2], mem_model[addrs[2]] ^ 16'h0011);
      do_mask(MASK_ALL);
      check_status();
      end_test("mask");

      // Write data for the host and the SUT
      for (i = 0; i < 6; i++) begin
         rnd          = $random(seed);
         host_data[i] = rnd[15:0];
         sut_data[i]  = rnd[31:16];
      end
      fork
         begin
            for (int k = 0; k < 6; k++) do_write(8'h40 + 8'(k), host_data[k]);
         end
         begin
            for (int k = 0; k < 6; k++) sut_write(8'hc0 + 8'(k), sut_data[k]);
         end
      join
      for (i = 0; i < 6; i++) do_check(8'hc0 + 8'(i), mem_model[8'hc0 + 8'(i)]);
      do_check(8'h45, mem_model[8'h45]);
      check_status();
      sut_read(8'h40);   // Host data seen from the SUT side
      end_test("shared_access");

      send_cmd(make_ctrl(CMD_FINISH, 8'h5a, '0));
      exp_done = 1'b1;
      exp_code = 8'h5a;
      check_status();
      apply_reset();
      do_check(addrs[3], '0);   // Memory is cleared again in the fresh segment
      check_status();
      @(posedge clk);
      sut_trap <= 1'b1;
      @(posedge clk);
      sut_trap <= 1'b0;
      exp_trap = 1'b1;
      @(posedge clk);
      check_status();
      end_test("finish_trap");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, total_errors());
      if (total_errors() == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

   // ------------------------------
   // Shared memory geometry
   // ------------------------------

   localparam int ADDR_W    = 8;
   localparam int RAM_DEPTH = 256;
   localparam int DATA_W    = 16;

   // ------------------------------
   // Wishbone classic signal groups
   // ------------------------------

   // Master to slave, 27 bits
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   // Slave to master, 17 bits
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;   // Read data, valid with ack
   } wb_rsp_t;

endpackage

//--- verilog/soc_reset_sync.sv
`timescale 1ns/1ns

module soc_reset_sync (
   input  logic clk,
   input  logic reset,
   input  logic init_done,
   output logic rst
);

   logic [1:0] sync_q;

   // Held while the RAM is still clearing
   always_ff @(posedge clk) begin
      if (reset || !init_done) begin
         sync_q <= 2'b11;
      end else begin
         sync_q <= {sync_q[0], 1'b0};   // Two cycles of release delay
      end
   end

   assign rst = sync_q[1];

endmodule

//--- verilog/soc_tester_top.sv
`timescale 1ns/1ns

module soc_tester_top (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        cmd_cyc,
   input  logic                        cmd_stb,
   input  tester_cmd_pkg::tester_cmd_u cmd_dat,
   output logic                        cmd_ack,
   input  soc_bus_pkg::wb_req_t        sut_req,
   output soc_bus_pkg::wb_rsp_t        sut_rsp,
   input  logic                        sut_trap,
   output logic                        trap,
   output logic                        done,
   output logic [7:0]                  err_count,
   output logic [7:0]                  fail_addr,
   output logic [7:0]                  finish_code
);

   import soc_bus_pkg::*;
   import tester_cmd_pkg::*;

   logic       rst;
   logic       init_done;
   logic       op_valid;
   logic       op_ready;
   tester_op_t op;
   check_t     check;
   wb_req_t    exec_req;
   wb_rsp_t    exec_rsp;
   wb_req_t    ram_req;
   wb_rsp_t    ram_rsp;

   // ------------------------------
   // Reset held until RAM is clear
   // ------------------------------

   soc_reset_sync rst_sync_i (
      .clk(clk), .reset(reset), .init_done(init_done), .rst(rst)
   );

   // ------------------------------
   // Tester pipeline
   // ------------------------------

   tester_decode decode_i (
      .clk(clk), .rst(rst),
      .cmd_cyc(cmd_cyc), .cmd_stb(cmd_stb), .cmd_dat(cmd_dat), .cmd_ack(cmd_ack),
      .op_valid(op_valid), .op(op), .op_ready(op_ready)
   );

   tester_exec exec_i (
      .clk(clk), .rst(rst),
      .op_valid(op_valid), .op(op), .op_ready(op_ready),
      .wb_req(exec_req), .wb_rsp(exec_rsp), .check(check)
   );

   // SUT trap merges into the sticky trap
   tester_result result_i (
      .clk(clk), .rst(rst), .check(check), .sut_trap(sut_trap),
      .trap(trap), .done(done), .err_count(err_count),
      .fail_addr(fail_addr), .finish_code(finish_code)
   );

   // ------------------------------
   // Shared memory path
   // ------------------------------

   wb_shared_arbiter arb_i (
      .clk(clk), .rst(rst),
      .m0_req(exec_req), .m0_rsp(exec_rsp),   // Tester
      .m1_req(sut_req), .m1_rsp(sut_rsp),     // Unit under test
      .s_req(ram_req), .s_rsp(ram_rsp)
   );

   wb_ram ram_i (
      .clk(clk), .reset(reset), .req(ram_req), .rsp(ram_rsp), .init_done(init_done)
   );

endmodule

//--- verilog/tester_cmd_pkg.sv
package tester_cmd_pkg;

   localparam logic [soc_bus_pkg::DATA_W-1:0] MASK_ALL = '1;

   typedef enum logic [1:0] {
      CMD_WRITE    = 2'd0,
      CMD_CHECK    = 2'd1,
      CMD_SET_MASK = 2'd2,
      CMD_FINISH   = 2'd3
   } cmd_op_e;

   // ------------------------------
   // Host command word views
   // ------------------------------

   // Used by CMD_WRITE and CMD_CHECK
   typedef struct packed {
      cmd_op_e                          opcode;
      logic [soc_bus_pkg::ADDR_W-1:0]   addr;
      logic [5:0]                       pad;
      logic [soc_bus_pkg::DATA_W-1:0]   data;
   } cmd_access_t;

   // Used by CMD_SET_MASK and CMD_FINISH
   typedef struct packed {
      cmd_op_e                          opcode;
      logic [7:0]                       finish_code;
      logic [5:0]                       pad;
      logic [soc_bus_pkg::DATA_W-1:0]   mask;
   } cmd_ctrl_t;

   typedef union packed {
      cmd_access_t access;
      cmd_ctrl_t   ctrl;
   } tester_cmd_u;

   // ------------------------------
   // Stage to stage records
   // ------------------------------

   typedef struct packed {
      cmd_op_e                          kind;
      logic [soc_bus_pkg::ADDR_W-1:0]   addr;
      logic [soc_bus_pkg::DATA_W-1:0]   data;
      logic [soc_bus_pkg::DATA_W-1:0]   mask;
      logic [7:0]                       finish_code;
   } tester_op_t;

   typedef struct packed {
      logic                             valid;
      cmd_op_e                          kind;
      logic [soc_bus_pkg::ADDR_W-1:0]   addr;
      logic [soc_bus_pkg::DATA_W-1:0]   rdata;
      logic [soc_bus_pkg::DATA_W-1:0]   expected;
      logic [soc_bus_pkg::DATA_W-1:0]   mask;
      logic [7:0]                       finish_code;
   } check_t;

endpackage

//--- verilog/tester_decode.sv
`timescale 1ns/1ns

module tester_decode (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        cmd_cyc,
   input  logic                        cmd_stb,
   input  tester_cmd_pkg::tester_cmd_u cmd_dat,
   output logic                        cmd_ack,
   output logic                        op_valid,
   output tester_cmd_pkg::tester_op_t  op,
   input  logic                        op_ready
);

   import tester_cmd_pkg::*;
   import soc_bus_pkg::*;

   logic              hold_valid;
   tester_op_t        hold_op;
   tester_op_t        next_op;
   logic [DATA_W-1:0] mask_q;
   logic              is_mask;
   logic              slot_free;
   logic              accept;

   assign is_mask   = (cmd_dat.access.opcode == CMD_SET_MASK);
   assign slot_free = !hold_valid || op_ready;   // Empty or emptying
   // One word per ack, never two acks in a row
   assign accept    = cmd_cyc && cmd_stb && !cmd_ack && (slot_free || is_mask);

   // The opcode picks which view of the word is meaningful
   always_comb begin
      next_op      = '0;
      next_op.kind = cmd_dat.access.opcode;
      next_op.mask = mask_q;
      case (cmd_dat.access.opcode)
         CMD_WRITE, CMD_CHECK: begin
            next_op.addr = cmd_dat.access.addr;
            next_op.data = cmd_dat.access.data;
         end
         CMD_FINISH: next_op.finish_code = cmd_dat.ctrl.finish_code;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_ack    <= 1'b0;
         hold_valid <= 1'b0;
         mask_q     <= MASK_ALL;
      end else begin
         cmd_ack <= accept;
         if (accept && !is_mask) begin
            hold_valid <= 1'b1;
         end else if (op_ready) begin
            hold_valid <= 1'b0;
         end
         if (accept && is_mask) mask_q <= cmd_dat.ctrl.mask;   // Applies to later checks
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !is_mask) hold_op <= next_op;
   end

   assign op_valid = hold_valid;
   assign op       = hold_op;

endmodule

//--- verilog/tester_exec.sv
`timescale 1ns/1ns

module tester_exec (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       op_valid,
   input  tester_cmd_pkg::tester_op_t op,
   output logic                       op_ready,
   output soc_bus_pkg::wb_req_t       wb_req,
   input  soc_bus_pkg::wb_rsp_t       wb_rsp,
   output tester_cmd_pkg::check_t     check
);

   import soc_bus_pkg::*;
   import tester_cmd_pkg::*;

   logic              busy;
   logic              chk_valid;
   tester_op_t        cur_op;
   logic [DATA_W-1:0] rdata_q;
   logic              take;

   assign op_ready = !busy;
   assign take     = op_valid && !busy;

   // ------------------------------
   // Bus cycle control
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= 1'b0;
         chk_valid <= 1'b0;
      end else begin
         chk_valid <= 1'b0;
         if (take) begin
            // Finish skips the bus but keeps its place in line
            if (op.kind == CMD_FINISH) chk_valid <= 1'b1;
            else busy <= 1'b1;
         end else if (busy && wb_rsp.ack) begin
            busy      <= 1'b0;
            chk_valid <= 1'b1;   // Record follows the ack
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) cur_op <= op;
      if (busy && wb_rsp.ack) rdata_q <= wb_rsp.dat;
   end

   // Held stable from accept until ack
   always_comb begin
      wb_req.cyc = busy;
      wb_req.stb = busy;
      wb_req.we  = (cur_op.kind == CMD_WRITE);
      wb_req.adr = cur_op.addr;
      wb_req.dat = cur_op.data;
   end

   always_comb begin
      check.valid       = chk_valid;
      check.kind        = cur_op.kind;
      check.addr        = cur_op.addr;
      check.rdata       = rdata_q;
      check.expected    = cur_op.data;
      check.mask        = cur_op.mask;
      check.finish_code = cur_op.finish_code;
   end

endmodule

//--- verilog/tester_result.sv
`timescale 1ns/1ns

module tester_result (
   input  logic                   clk,
   input  logic                   rst,
   input  tester_cmd_pkg::check_t check,
   input  logic                   sut_trap,
   output logic                   trap,
   output logic                   done,
   output logic [7:0]             err_count,
   output logic [7:0]             fail_addr,
   output logic [7:0]             finish_code
);

   import tester_cmd_pkg::*;

   logic is_fail;
   logic is_finish;

   // Only bits under the mask count
   assign is_fail   = check.valid && (check.kind == CMD_CHECK) &&
                      (((check.rdata ^ check.expected) & check.mask) != '0);
   assign is_finish = check.valid && (check.kind == CMD_FINISH);

   always_ff @(posedge clk) begin
      if (rst) begin
         trap      <= 1'b0;
         done      <= 1'b0;
         err_count <= '0;
      end else begin
         if (is_fail || sut_trap) trap <= 1'b1;   // Sticky
         if (is_fail && err_count != 8'hff) err_count <= err_count + 8'd1;
         if (is_finish) done <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (is_fail) fail_addr <= check.addr;
      if (is_finish) finish_code <= check.finish_code;
   end

endmodule

//--- verilog/wb_ram.sv
`timescale 1ns/1ns

module wb_ram (
   input  logic                 clk,
   input  logic                 reset,
   input  soc_bus_pkg::wb_req_t req,
   output soc_bus_pkg::wb_rsp_t rsp,
   output logic                 init_done
);

   import soc_bus_pkg::*;

   logic [DATA_W-1:0] mem [RAM_DEPTH];
   logic [ADDR_W-1:0] clr_addr;
   logic [DATA_W-1:0] rdata_q;
   logic              ack_q;
   logic              hit;

   assign hit = init_done && req.cyc && req.stb && !ack_q;   // First cycle of a request

   // Clear sweep after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         clr_addr  <= '0;
         init_done <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= hit;
         if (!init_done) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == ADDR_W'(RAM_DEPTH - 1)) init_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!init_done) begin
         mem[clr_addr] <= '0;
      end else if (hit && req.we) begin
         mem[req.adr] <= req.dat;
      end
      if (hit) rdata_q <= mem[req.adr];   // Lines up with ack
   end

   assign rsp.ack = ack_q;
   assign rsp.dat = rdata_q;

endmodule

//--- verilog/wb_shared_arbiter.sv
`timescale 1ns/1ns

module wb_shared_arbiter (
   input  logic                 clk,
   input  logic                 rst,
   input  soc_bus_pkg::wb_req_t m0_req,
   output soc_bus_pkg::wb_rsp_t m0_rsp,
   input  soc_bus_pkg::wb_req_t m1_req,
   output soc_bus_pkg::wb_rsp_t m1_rsp,
   output soc_bus_pkg::wb_req_t s_req,
   input  soc_bus_pkg::wb_rsp_t s_rsp
);

   import soc_bus_pkg::*;

   logic [1:0] gnt;        // One-hot, zero when idle
   logic       last_sel;   // Winner of the previous grant
   logic       pick;
   logic       owner_cyc;

   // Last winner loses a tie
   assign pick      = m1_req.cyc && (!m0_req.cyc || !last_sel);
   assign owner_cyc = (gnt[0] && m0_req.cyc) || (gnt[1] && m1_req.cyc);

   always_ff @(posedge clk) begin
      if (rst) begin
         gnt      <= 2'b00;
         last_sel <= 1'b1;
      end else if (gnt == 2'b00) begin
         if (m0_req.cyc || m1_req.cyc) begin
            gnt      <= pick ? 2'b10 : 2'b01;
            last_sel <= pick;
         end
      end else if (!owner_cyc) begin
         gnt <= 2'b00;   // Released after cyc drops
      end
   end

   // ------------------------------
   // Request and response muxing
   // ------------------------------

   always_comb begin
      s_req = '0;
      if (gnt[0]) s_req = m0_req;
      else if (gnt[1]) s_req = m1_req;
   end

   assign m0_rsp = gnt[0] ? s_rsp : '0;
   assign m1_rsp = gnt[1] ? s_rsp : '0;

endmodule
